// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - target: rtl
    files:
      - source/fetch_pkg.sv
      - source/fetch_unit.sv
      - source/branch_handler.sv
      - source/decode_queue.sv
      - source/branch_commit.sv
      - source/fetch_top.sv
  - target: tb
    files:
      - source/fetch_pkg.sv
      - source/fetch_unit.sv
      - source/branch_handler.sv
      - source/decode_queue.sv
      - source/branch_commit.sv
      - source/fetch_top.sv
      - tb/fetch_checker.sv
      - tb/fetch_tb.sv

// ==== build.f ====
source/fetch_pkg.sv
source/fetch_unit.sv
source/branch_handler.sv
source/decode_queue.sv
source/branch_commit.sv
source/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// ==== source/branch_commit.sv ====
module branch_commit (
   input  logic                       clk,
   input  logic                       rst_n,
   input  fetch_pkg::filtered_group_t group,
   input  logic                       not_empty,
   input  logic                       resolve_taken,
   output logic                       pop,
   output logic                       retire_valid,
   output fetch_pkg::inst_t           retire_inst,
   output logic                       decr_count,
   output logic                       mispred_num,
   output logic                       mispredict
);
   import fetch_pkg::*;

   filtered_group_t        cur;
   logic [group_width-1:0] cur_live;
   logic [group_width-1:0] sel;
   logic [group_width-1:0] live_after;
   logic [group_width-1:0] load_live;
   inst_t                  sel_inst;
   logic                   sel_branch;
   logic                   sel_pred;
   logic                   retire_branch;
   logic                   retire_pred;
   logic                   retire_more;

   // oldest live slot, lowest index wins
   always_comb begin
      sel        = '0;
      sel_inst   = nop_inst;
      sel_branch = 1'b0;
      sel_pred   = 1'b0;
      for (int k = group_width - 1; k >= 0; k--) begin
         if (cur_live[k]) begin
            sel        = '0;
            sel[k]     = 1'b1;
            sel_inst   = cur.slot[k];
            sel_branch = cur.branch[k];
            sel_pred   = cur.taken[k];
         end
      end
   end

   assign live_after = cur_live & ~sel;

   // non-nop words of the incoming group
   always_comb begin
      for (int k = 0; k < group_width; k++) begin
         load_live[k] = (group.slot[k] != nop_inst);
      end
   end

   // take the next group as the last word of this one leaves
   assign pop = not_empty && (live_after == '0);

   //////////////////////////////////////////////////////////////////////
   // retire stage
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cur_live     <= '0;
         retire_valid <= 1'b0;
      end else begin
         retire_valid <= |cur_live;
         cur_live     <= pop ? load_live : live_after;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         cur <= group;
      end
      retire_inst   <= sel_inst;
      retire_branch <= sel_branch;
      retire_pred   <= sel_pred;
      // younger branch still counted, here or in the group just popped
      retire_more   <= (|(cur.branch & live_after)) || (pop && (|group.branch));
   end

   // outcome arrives with the retiring branch
   assign decr_count  = retire_valid && retire_branch;
   assign mispredict  = decr_count && (resolve_taken != retire_pred);
   assign mispred_num = mispredict && retire_more;

endmodule

// ==== source/branch_handler.sv ====
module branch_handler (
   input  logic                       clk,
   input  logic                       rst_n,
   input  fetch_pkg::fetch_group_t    group,
   input  logic [1:0]                 pred_taken,
   input  logic                       stall_for_jump,
   input  logic                       stall_fetch,
   input  logic                       decr_count,
   input  logic                       mispred_num,
   output fetch_pkg::filtered_group_t filtered,
   output logic                       push,
   output logic                       pcsel,
   output logic [15:0]                pc_next,
   output logic [15:0]                taken_target,
   output logic                       redirect,
   output logic                       update_bpred
);
   import fetch_pkg::*;

   op_e                    op [group_width];
   logic [1:0]             branch_count;
   logic                   hold;
   logic                   third;
   logic [15:0]            drop_pc;
   logic [group_width-1:0] live;
   logic [2:0]             incr;
   logic [2:0]             decr;
   logic [2:0]             count_sum;

   // slot classes
   always_comb begin
      for (int k = 0; k < group_width; k++) begin
         op[k] = classify(group.slot[k]);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // nop filter
   //////////////////////////////////////////////////////////////////////

   // walk oldest to youngest, once cut every later slot is a nop
   // nop causes: stall, jump, predicted taken, branch over the limit
   always_comb begin : filter
      logic       cut;
      logic [2:0] seen;
      logic       nth;
      // stalls and the third-branch hold wipe the whole group
      cut          = stall_fetch || stall_for_jump || hold;
      // branches in flight plus those earlier in this group
      seen         = {1'b0, branch_count};
      // first or second branch of the group picks its prediction bit
      nth          = 1'b0;
      filtered     = '0;
      third        = 1'b0;
      redirect     = 1'b0;
      taken_target = '0;
      drop_pc      = group.pc;
      for (int k = 0; k < group_width; k++) begin
         if (!cut) begin
            if (op[k] == op_branch && seen >= max_branches) begin
               // over the limit, drop it and refetch from here
               third   = 1'b1;
               drop_pc = group.pc + 16'(k);
               cut     = 1'b1;
            end else begin
               filtered.slot[k] = group.slot[k];
               if (op[k] == op_branch) begin
                  filtered.branch[k] = 1'b1;
                  filtered.taken[k]  = pred_taken[nth];
                  if (pred_taken[nth]) begin
                     redirect     = 1'b1;
                     taken_target = target_of(group.slot[k]);
                     cut          = 1'b1;
                  end
                  seen = seen + 3'd1;
                  nth  = 1'b1;
               end else if (op[k] == op_jump) begin
                  // register jump waits in fetch, immediate goes now
                  cut = 1'b1;
                  if (is_imm_jump(group.slot[k])) begin
                     redirect     = 1'b1;
                     taken_target = target_of(group.slot[k]);
                  end
               end
            end
         end
      end
   end

   // live words left after filtering
   always_comb begin
      for (int k = 0; k < group_width; k++) begin
         live[k] = (filtered.slot[k] != nop_inst);
      end
   end

   assign push = (|live) && !stall_fetch;

   // refetch the dropped slot, or the same group on a stall
   assign pcsel   = stall_fetch || hold || third;
   assign pc_next = drop_pc;

   // kept branches are handed to the predictor
   assign update_bpred = push && (|filtered.branch);

   //////////////////////////////////////////////////////////////////////
   // branch counter and hold flag
   //////////////////////////////////////////////////////////////////////

   // branches entering the queue this cycle
   always_comb begin
      incr = '0;
      for (int k = 0; k < group_width; k++) begin
         incr = incr + 3'(filtered.branch[k]);
      end
      if (!push) begin
         incr = '0;
      end
   end

   // commit retires one, or two on a misprediction with a younger branch
   assign decr      = !decr_count ? 3'd0 : (mispred_num ? 3'd2 : 3'd1);
   assign count_sum = {1'b0, branch_count} + incr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         branch_count <= '0;
      end else if (count_sum > decr) begin
         branch_count <= 2'(count_sum - decr);
      end else begin
         branch_count <= '0;
      end
   end

   // hold after a dropped branch until a slot frees up
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold <= 1'b0;
      end else if (third) begin
         hold <= 1'b1;
      end else if (branch_count < max_branches) begin
         hold <= 1'b0;
      end
   end

endmodule

// ==== source/decode_queue.sv ====
module decode_queue #(
   parameter int queue_depth = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       push,
   input  fetch_pkg::filtered_group_t in_group,
   input  logic                       pop,
   output fetch_pkg::filtered_group_t out_group,
   output logic                       not_empty,
   output logic                       full
);
   import fetch_pkg::*;

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);

   filtered_group_t  entries [queue_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   // pointer step with wrap at the depth
   function automatic logic [ptr_w-1:0] bump(logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // writes into a full queue are dropped
   assign do_push = push && !full;
   assign do_pop  = pop && not_empty;

   assign not_empty = (count != '0);
   assign full      = (count == cnt_w'(queue_depth));

   // head entry, visible the cycle after its push
   assign out_group = entries[rd_ptr];

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         entries[wr_ptr] <= in_group;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // pointers and occupancy
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= bump(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= bump(rd_ptr);
         end
         // simultaneous push and pop leaves the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

   //////////////////////////////////////////////////////////////////////
   // front end sizes
   //////////////////////////////////////////////////////////////////////

   // slots per fetch group
   localparam int group_width = 4;
   // branches allowed between fetch and commit
   localparam int max_branches = 2;

   // one 16-bit instruction word
   typedef logic [15:0] inst_t;

   // the all-zero word doubles as the nop
   localparam inst_t nop_inst = 16'h0000;

   // classes decoded from the top nibble
   typedef enum logic [1:0] {
      op_alu,
      op_branch,
      op_jump
   } op_e;

   // raw group from fetch, slot[0] is the oldest word
   typedef struct packed {
      logic [15:0]             pc;
      inst_t [group_width-1:0] slot;
   } fetch_group_t;

   // queue entry after filtering
   typedef struct packed {
      inst_t [group_width-1:0] slot;
      logic [group_width-1:0]  branch;
      logic [group_width-1:0]  taken;
   } filtered_group_t;

   // 1111 is a jump, 10xx with xx != 00 is a branch
   function automatic op_e classify(inst_t inst);
      op_e op;
      if (inst[15:12] == 4'hf) begin
         op = op_jump;
      end else if (inst[15:14] == 2'b10 && inst[13:12] != 2'b00) begin
         op = op_branch;
      end else begin
         op = op_alu;
      end
      return op;
   endfunction

   // low bits 00 mark an immediate jump
   function automatic logic is_imm_jump(inst_t inst);
      return (classify(inst) == op_jump) && (inst[1:0] == 2'b00);
   endfunction

   // 12-bit target field, zero-extended
   function automatic logic [15:0] target_of(inst_t inst);
      return {4'h0, inst[11:0]};
   endfunction

endpackage

// ==== source/fetch_top.sv ====
module fetch_top #(
   parameter int queue_depth = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [1:0]       pred_taken,
   input  logic             resolve_taken,
   input  logic [15:0]      reg_jump_target,
   input  logic             reg_jump_valid,
   input  logic             imem_we,
   input  logic [11:0]      imem_addr,
   input  fetch_pkg::inst_t imem_wdata,
   output logic             retire_valid,
   output fetch_pkg::inst_t retire_inst,
   output logic             mispredict,
   output logic             update_bpred
);
   import fetch_pkg::*;

   fetch_group_t    group;
   filtered_group_t filtered;
   filtered_group_t queue_out;
   logic            push;
   logic            pcsel;
   logic            redirect;
   logic            stall_for_jump;
   logic            not_empty;
   logic            full;
   logic            pop;
   logic            decr_count;
   logic            mispred_num;
   logic [15:0]     pc_next;
   logic [15:0]     taken_target;

   // pc, memory and group register
   fetch_unit i_fetch (
      .clk             (clk),
      .rst_n           (rst_n),
      .pcsel           (pcsel),
      .pc_next         (pc_next),
      .taken_target    (taken_target),
      .redirect        (redirect),
      .reg_jump_target (reg_jump_target),
      .reg_jump_valid  (reg_jump_valid),
      .imem_we         (imem_we),
      .imem_addr       (imem_addr),
      .imem_wdata      (imem_wdata),
      .group           (group),
      .stall_for_jump  (stall_for_jump)
   );

   // full queue stalls the filter
   branch_handler i_handler (
      .clk            (clk),
      .rst_n          (rst_n),
      .group          (group),
      .pred_taken     (pred_taken),
      .stall_for_jump (stall_for_jump),
      .stall_fetch    (full),
      .decr_count     (decr_count),
      .mispred_num    (mispred_num),
      .filtered       (filtered),
      .push           (push),
      .pcsel          (pcsel),
      .pc_next        (pc_next),
      .taken_target   (taken_target),
      .redirect       (redirect),
      .update_bpred   (update_bpred)
   );

   decode_queue #(
      .queue_depth (queue_depth)
   ) i_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .in_group  (filtered),
      .pop       (pop),
      .out_group (queue_out),
      .not_empty (not_empty),
      .full      (full)
   );

   // in-order retirement
   branch_commit i_commit (
      .clk           (clk),
      .rst_n         (rst_n),
      .group         (queue_out),
      .not_empty     (not_empty),
      .resolve_taken (resolve_taken),
      .pop           (pop),
      .retire_valid  (retire_valid),
      .retire_inst   (retire_inst),
      .decr_count    (decr_count),
      .mispred_num   (mispred_num),
      .mispredict    (mispredict)
   );

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    pcsel,
   input  logic [15:0]             pc_next,
   input  logic [15:0]             taken_target,
   input  logic                    redirect,
   input  logic [15:0]             reg_jump_target,
   input  logic                    reg_jump_valid,
   input  logic                    imem_we,
   input  logic [11:0]             imem_addr,
   input  fetch_pkg::inst_t        imem_wdata,
   output fetch_pkg::fetch_group_t group,
   output logic                    stall_for_jump
);
   import fetch_pkg::*;

   typedef enum logic {
      run,
      wait_jump
   } state_e;

   state_e      state;
   logic [15:0] pc;
   logic [15:0] pc_d;
   logic        reg_jump_seen;
   logic        enter_wait;
   logic        squash;
   inst_t       imem [0:4095];

   // instruction memory write port
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // register jump somewhere in the current group
   // slots behind an earlier redirect are excluded below via pcsel/redirect
   always_comb begin
      reg_jump_seen = 1'b0;
      for (int k = 0; k < group_width; k++) begin
         if (classify(group.slot[k]) == op_jump && !is_imm_jump(group.slot[k])) begin
            reg_jump_seen = 1'b1;
         end
      end
   end

   // wait only if nothing older in the group redirected fetch
   assign enter_wait = (state == run) && reg_jump_seen && !pcsel && !redirect;

   // group being read this edge is wrong path
   assign squash = (state == wait_jump) || pcsel || redirect || enter_wait;

   assign stall_for_jump = (state == wait_jump);

   //////////////////////////////////////////////////////////////////////
   // next pc
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      pc_d = pc + 16'd4;
      if (state == wait_jump) begin
         // hold until the register target shows up
         pc_d = reg_jump_valid ? reg_jump_target : pc;
      end else if (pcsel) begin
         pc_d = pc_next;
      end else if (redirect) begin
         pc_d = taken_target;
      end else if (enter_wait) begin
         pc_d = pc;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= run;
      end else if (enter_wait) begin
         state <= wait_jump;
      end else if (state == wait_jump && reg_jump_valid) begin
         state <= run;
      end
   end

   // pc and registered group
   // a squashed group carries the new pc so a refetch lands there
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc    <= '0;
         group <= '0;
      end else begin
         pc <= pc_d;
         if (squash) begin
            group.pc   <= pc_d;
            group.slot <= '0;
         end else begin
            group.pc <= pc;
            for (int k = 0; k < group_width; k++) begin
               // 12-bit address wraps inside the memory
               group.slot[k] <= imem[pc[11:0] + 12'(k)];
            end
         end
      end
   end

endmodule

// ==== tb/fetch_checker.sv ====
module fetch_checker (
   input logic       clk,
   input logic       rst_n,
   input logic [1:0] branch_count,
   input logic       push,
   input logic       pop,
   input logic       full,
   input logic       not_empty
);
   timeunit 1ns;
   timeprecision 1ps;
   import fetch_pkg::*;

   // assertion failures so far
   int errors = 0;

   // in-flight branch counter never exceeds the limit
   a_branch_limit : assert property (@(posedge clk) disable iff (!rst_n)
      branch_count <= max_branches)
      else begin
         $error("branch counter above the in-flight limit");
         errors++;
      end

   // full queue stays full until a pop
   a_full_holds : assert property (@(posedge clk) disable iff (!rst_n)
      full && !pop |=> full)
      else begin
         $error("full queue changed occupancy without a pop");
         errors++;
      end

   // push into an empty queue shows at the head next cycle
   a_push_visible : assert property (@(posedge clk) disable iff (!rst_n)
      push && !not_empty |=> not_empty)
      else begin
         $error("queue still empty the cycle after a push");
         errors++;
      end

endmodule

// ==== tb/fetch_tb.sv ====
module fetch_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import fetch_pkg::*;

   localparam int          queue_depth    = 4;
   localparam int          timeout_cycles = 2000;
   localparam logic [15:0] reg_target     = 16'h0080;

   logic        clk;
   logic        rst_n;
   logic [1:0]  pred_taken;
   logic        resolve_taken;
   logic [15:0] reg_jump_target;
   logic        reg_jump_valid;
   logic        imem_we;
   logic [11:0] imem_addr;
   inst_t       imem_wdata;
   logic        retire_valid;
   inst_t       retire_inst;
   logic        mispredict;
   logic        update_bpred;
   integer      seed = 15499;
   inst_t       expected [$];
   int          retired;
   int          bpred_updates;
   logic        checking;
   logic        phase_pred;
   string       test_name;

   fetch_top #(.queue_depth(queue_depth)) i_dut (
      .clk (clk), .rst_n (rst_n), .pred_taken (pred_taken),
      .resolve_taken (resolve_taken), .reg_jump_target (reg_jump_target),
      .reg_jump_valid (reg_jump_valid), .imem_we (imem_we), .imem_addr (imem_addr),
      .imem_wdata (imem_wdata), .retire_valid (retire_valid),
      .retire_inst (retire_inst), .mispredict (mispredict), .update_bpred (update_bpred)
   );

   bind fetch_top fetch_checker i_checker (
      .clk (clk), .rst_n (rst_n), .branch_count (i_handler.branch_count),
      .push (push), .pop (pop), .full (full), .not_empty (not_empty)
   );

   always #5 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // program and reference model
   //////////////////////////////////////////////////////////////////////

   // test program over alu filler tagged by address
   function automatic inst_t prog_word(logic [11:0] addr);
      case (addr)
         12'h006: return 16'hf020;  // imm jump to 0x020
         12'h021: return 16'h9040;  // branch to 0x040
         12'h022: return 16'ha050;
         12'h023: return 16'hb060;  // third branch in a row
         12'h025: return 16'h9070;
         12'h027: return 16'hf001;  // register jump
         12'h041: return 16'h9044;
         12'h045: return 16'hf002;  // register jump
         12'h084: return 16'hf084;  // jump to self as end of program
         default: return {4'h1, addr};
      endcase
   endfunction

   function automatic logic is_branch_word(inst_t w);
      return (w[15:14] == 2'b10) && (w[13:12] != 2'b00);
   endfunction

   // walks the program in order with one prediction per phase
   function automatic void expected_stream(logic pred);
      logic [15:0] pc;
      inst_t       w;
      logic        done;
      expected.delete();
      pc   = '0;
      done = 1'b0;
      for (int n = 0; n < 64 && !done; n++) begin
         w = prog_word(pc[11:0]);
         expected.push_back(w);
         if (w[15:12] == 4'hf) begin
            if (w[1:0] != 2'b00) begin
               pc = reg_target;
            end else if ({4'h0, w[11:0]} == pc) begin
               done = 1'b1;
            end else begin
               pc = {4'h0, w[11:0]};
            end
         end else if (is_branch_word(w) && pred) begin
            pc = {4'h0, w[11:0]};
         end else begin
            pc = pc + 16'd1;
         end
      end
   endfunction

   task automatic stop_with_failure();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   // random outcome and register-target strobe every cycle
   always @(posedge clk) begin
      resolve_taken  <= 1'($random(seed));
      reg_jump_valid <= (2'($random(seed)) == 2'b00);
   end

   //////////////////////////////////////////////////////////////////////
   // comparing process
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      logic exp_mispredict;
      // predictor updates counted per phase
      if (checking && update_bpred) begin
         bpred_updates++;
      end
      if (checking && retire_valid && retired < expected.size()) begin
         exp_mispredict = is_branch_word(expected[retired]) && (resolve_taken != phase_pred);
         assert (retire_inst == expected[retired]) else begin
            $error("Mismatch in %s word %0d: expected %h, actual %h",
                   test_name, retired, expected[retired], retire_inst);
            stop_with_failure();
         end
         assert (mispredict == exp_mispredict) else begin
            $error("Mismatch in %s mispredict at word %0d: expected %b, actual %b",
                   test_name, retired, exp_mispredict, mispredict);
            stop_with_failure();
         end
         retired++;
      end else if (checking && !retire_valid) begin
         assert (!mispredict) else begin
            $error("mispredict pulsed in %s with no word retiring", test_name);
            stop_with_failure();
         end
      end
   end

   // bound assertions stop the run at their first failure
   always @(negedge clk) begin
      if (i_dut.i_checker.errors != 0) begin
         $error("bound assertion failed during %s", test_name);
         stop_with_failure();
      end
   end

   // whole memory written while reset is held
   task automatic load_program();
      for (int a = 0; a < 4096; a++) begin
         @(posedge clk);
         imem_we    <= 1'b1;
         imem_addr  <= 12'(a);
         imem_wdata <= prog_word(12'(a));
      end
      @(posedge clk);
      imem_we <= 1'b0;
   endtask

   task automatic run_phase(input logic pred, input string name);
      int cycles;
      int branches;
      checking = 1'b0;
      @(posedge clk);
      rst_n      <= 1'b0;
      pred_taken <= {pred, pred};
      repeat (3) @(posedge clk);
      test_name  = name;
      phase_pred = pred;
      expected_stream(pred);
      retired       = 0;
      bpred_updates = 0;
      checking      = 1'b1;
      rst_n        <= 1'b1;
      cycles        = 0;
      while (retired < expected.size()) begin
         @(posedge clk);
         cycles++;
         if (cycles > timeout_cycles) begin
            $error("timeout in %s, only %0d of %0d words retired",
                   name, retired, expected.size());
            stop_with_failure();
         end
      end
      checking = 1'b0;
      // each branch enters the queue once, at most one pulse per branch
      branches = 0;
      foreach (expected[i]) begin
         if (is_branch_word(expected[i])) begin
            branches++;
         end
      end
      assert (bpred_updates > 0 && bpred_updates <= branches) else begin
         $error("update_bpred pulsed %0d times in %s for %0d branch words",
                bpred_updates, name, branches);
         stop_with_failure();
      end
   endtask

   initial begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      pred_taken      = 2'b00;
      resolve_taken   = 1'b0;
      reg_jump_target = reg_target;
      reg_jump_valid  = 1'b0;
      imem_we         = 1'b0;
      imem_addr       = '0;
      imem_wdata      = '0;
      checking        = 1'b0;
      retired         = 0;
      bpred_updates   = 0;
      phase_pred      = 1'b0;
      load_program();
      // fall-through path, branch limit, register jump
      run_phase(1'b0, "not_taken");
      // taken branches redirect
      run_phase(1'b1, "taken");
      // let the last edge's assertion actions settle
      @(negedge clk);
      if (i_dut.i_checker.errors == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

endmodule
